// ==== source/ppu_defines.svh ====
`ifndef PPU_DEFINES_SVH
`define PPU_DEFINES_SVH

`define PPU_N               8  // posit word width
`define PPU_ES              0  // exponent field size

// signed total exponent wide enough to hold the sum of two operand exponents
`define PPU_TE_BITS         (`PPU_ES + $clog2(`PPU_N) + 2)

`define PPU_FRAC_FULL_SIZE  (`PPU_N - `PPU_ES - 2)  // fraction bits plus the hidden one

`endif

// ==== source/ppu_pkg.sv ====
`include "ppu_defines.svh"

package ppu_pkg;

  typedef logic [`PPU_N-1:0] posit_t;

  typedef enum logic [1:0] {
    OP_NOP = 2'd0,
    OP_ADD = 2'd1,
    OP_SUB = 2'd2,
    OP_MUL = 2'd3
  } operation_e;

  typedef logic signed [`PPU_TE_BITS-1:0] exponent_t;

  // decoded operand, value is (-1)^sign * 1.frac * 2^total_exponent
  typedef struct packed {
    logic                           sign;
    exponent_t                      total_exponent;
    logic [`PPU_FRAC_FULL_SIZE-1:0] frac;  // hidden one sits at the msb
  } fir_t;

  typedef struct packed {
    logic   is_zero;
    logic   is_nar;
    posit_t posit;  // forced result when either flag is set
  } posit_special_t;

  typedef struct packed {
    logic                             sign;
    exponent_t                        total_exponent;
    logic [2*`PPU_FRAC_FULL_SIZE-1:0] frac;  // binary point sits below the top two bits
    logic                             sticky;  // or of every bit dropped during alignment
  } ops_result_t;

endpackage

// ==== source/extraction.sv ====
`include "ppu_defines.svh"

module extraction #(
  parameter int N  = `PPU_N,
  parameter int ES = `PPU_ES
) (
  input  ppu_pkg::posit_t         p1_i,
  input  ppu_pkg::posit_t         p2_i,
  input  ppu_pkg::operation_e     op_i,
  output ppu_pkg::fir_t           fir1_o,
  output ppu_pkg::fir_t           fir2_o,
  output ppu_pkg::posit_special_t p_special_o
);

  import ppu_pkg::*;

  localparam int     F   = `PPU_FRAC_FULL_SIZE;
  localparam posit_t NAR = {1'b1, {(N - 1){1'b0}}};

  logic zero1;
  logic zero2;
  logic nar1;
  logic nar2;

  function automatic fir_t decode(input posit_t p);
    fir_t         fir;
    posit_t       mag;
    logic [N-2:0] body;
    logic [N-2:0] rest;
    logic         run_on;
    int           run;
    int           k;
    int           exp_val;
    mag = p[N-1] ? (~p + 1'b1) : p;  // negative posits decode from their two's complement
    body = mag[N-2:0];
    run = 0;
    run_on = 1'b1;
    for (int i = N - 2; i >= 0; i--) begin
      run_on = run_on & (body[i] == body[N-2]);  // leading run of the regime bit
      run = run + int'(run_on);
    end
    k = body[N-2] ? run - 1 : -run;
    rest = body << (run + 1);  // drop regime and its terminating bit
    exp_val = int'(rest >> (N - 1 - ES));
    fir.sign = p[N-1];
    fir.total_exponent = exponent_t'(k * (1 << ES) + exp_val);
    fir.frac = {1'b1, rest[N-2-ES -: F-1]};
    if (p == '0) begin
      // zero sits below minpos so it never wins the alignment compare
      fir.total_exponent = exponent_t'(-(N - 1) * (1 << ES));
      fir.frac = '0;
    end
    return fir;
  endfunction

  assign zero1 = (p1_i == '0);
  assign zero2 = (p2_i == '0);
  assign nar1  = (p1_i == NAR);
  assign nar2  = (p2_i == NAR);

  always_comb begin
    fir1_o = decode(p1_i);
    fir2_o = decode(p2_i);
    if (op_i == OP_SUB) begin
      fir2_o.sign = ~fir2_o.sign;  // a - b is handled as a + (-b)
    end
    p_special_o.is_nar  = (op_i != OP_NOP) && (nar1 || nar2);
    // a nop always yields the zero posit, like the cleared register
    p_special_o.is_zero = (op_i == OP_NOP) ||
                          ((op_i == OP_MUL) && (zero1 || zero2) && !(nar1 || nar2));
    p_special_o.posit   = p_special_o.is_nar ? NAR : '0;
  end

endmodule

// ==== source/fir_ops.sv ====
`include "ppu_defines.svh"

module fir_ops #(
  parameter int N = `PPU_N
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    stall_i,
  input  ppu_pkg::operation_e     op_i,
  input  ppu_pkg::fir_t           fir1_i,
  input  ppu_pkg::fir_t           fir2_i,
  input  ppu_pkg::posit_special_t p_special_i,
  output ppu_pkg::ops_result_t    ops_result_o,
  output ppu_pkg::posit_special_t special_o,
  output ppu_pkg::operation_e     op_o
);

  import ppu_pkg::*;

  localparam int F   = `PPU_FRAC_FULL_SIZE;
  localparam int W   = 2 * F;  // raw result width that fits the full product
  localparam int SHW = $clog2(2 * N) + 1;  // enough to hold a shift clamped at W

  fir_t           big_fir;
  fir_t           small_fir;
  logic [SHW-1:0] shamt;
  logic [W-1:0]   big_al;
  logic [W-1:0]   small_al;
  logic [2*W-1:0] small_sh;
  logic           sticky_add;
  logic [W-1:0]   add_mag;
  logic           add_sign;
  ops_result_t    sum_res;
  ops_result_t    mul_res;
  ops_result_t    result_d;
  ops_result_t    result_q;
  posit_special_t special_q;
  operation_e     op_q;

  always_comb begin : align
    int diff;
    if (fir1_i.total_exponent >= fir2_i.total_exponent) begin
      big_fir   = fir1_i;
      small_fir = fir2_i;
    end else begin
      big_fir   = fir2_i;
      small_fir = fir1_i;
    end
    diff = int'(big_fir.total_exponent) - int'(small_fir.total_exponent);
    shamt = (diff > W) ? SHW'(W) : SHW'(diff);  // past W every bit is already sticky
    big_al = W'(big_fir.frac) << (F - 1);
    // lower half catches the bits shifted out of the aligned word
    small_sh = {W'(small_fir.frac) << (F - 1), {W{1'b0}}} >> shamt;
    small_al = small_sh[2*W-1:W];
    sticky_add = |small_sh[W-1:0];
  end

  always_comb begin : add_sub
    if (big_fir.sign == small_fir.sign) begin
      add_mag  = big_al + small_al;
      add_sign = big_fir.sign;
    end else if (big_al >= small_al) begin
      // dropped bits make the true difference slightly smaller, so borrow one lsb
      add_mag  = big_al - small_al - W'(sticky_add);
      add_sign = big_fir.sign;
    end else begin
      add_mag  = small_al - big_al;  // only reached with equal exponents where no bit is dropped
      add_sign = small_fir.sign;
    end
    sum_res.sign           = add_sign;
    sum_res.total_exponent = big_fir.total_exponent;
    sum_res.frac           = add_mag;
    sum_res.sticky         = sticky_add;
  end

  always_comb begin : mul
    mul_res.sign           = fir1_i.sign ^ fir2_i.sign;
    mul_res.total_exponent = fir1_i.total_exponent + fir2_i.total_exponent;
    mul_res.frac           = fir1_i.frac * fir2_i.frac;  // exact product with a value in [1, 4)
    mul_res.sticky         = 1'b0;
  end

  assign result_d = (op_i == OP_MUL) ? mul_res : sum_res;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      result_q  <= '0;
      special_q <= '0;
      op_q      <= OP_NOP;
    end else if (!stall_i) begin
      result_q  <= result_d;
      special_q <= p_special_i;  // stays aligned with its own operands
      op_q      <= op_i;
    end
  end

  assign ops_result_o = result_q;
  assign special_o    = special_q;
  assign op_o         = op_q;

endmodule

// ==== source/normalization.sv ====
`include "ppu_defines.svh"

module normalization #(
  parameter int N  = `PPU_N,
  parameter int ES = `PPU_ES
) (
  input  ppu_pkg::ops_result_t    ops_result_i,
  input  ppu_pkg::posit_special_t p_special_i,
  output ppu_pkg::posit_t         posit_o
);

  import ppu_pkg::*;

  localparam int     F      = `PPU_FRAC_FULL_SIZE;
  localparam int     W      = 2 * F;
  localparam int     T      = ES + W - 1;  // exponent and fraction bits behind the regime
  localparam int     BW     = N + T;
  localparam posit_t MAXPOS = {1'b0, {(N - 1){1'b1}}};
  localparam posit_t MINPOS = posit_t'(1);

  int             msb;
  int             te_n;
  int             k;
  int             kc;
  int             rl;
  int             e_val;
  logic [W-1:0]   norm;
  logic [T-1:0]   tail;
  logic [N-1:0]   regime_word;
  logic [BW-1:0]  bits;
  logic [N-2:0]   body;
  logic           guard;
  logic           round_sticky;
  logic           round_up;
  posit_t         mag;
  posit_t         posit;

  always_comb begin
    msb = 0;
    for (int i = 0; i < W; i++) begin
      if (ops_result_i.frac[i]) begin
        msb = i;  // position of the leading one
      end
    end
    te_n  = int'(ops_result_i.total_exponent) + msb - (W - 2);
    k     = te_n >>> ES;  // floor division by 2^es
    e_val = te_n - k * (1 << ES);
    norm  = ops_result_i.frac << (W - 1 - msb);
    tail  = T'(norm[W-2:0]) | (T'(e_val) << (W - 1));

    // clamped copy keeps the shifts in range, saturation below covers the rest
    kc = (k > N - 2) ? N - 2 : ((k < -(N - 1)) ? -(N - 1) : k);
    if (kc >= 0) begin
      regime_word = ~({N{1'b1}} >> (kc + 1));  // kc+1 ones then a zero
      rl = kc + 2;
    end else begin
      regime_word = {1'b1, {(N - 1){1'b0}}} >> (-kc);  // -kc zeros then a one
      rl = 1 - kc;
    end
    bits = {regime_word, {T{1'b0}}} | (BW'(tail) << (N - rl));

    body         = bits[BW-1 -: N-1];
    guard        = bits[T];
    round_sticky = (|bits[T-1:0]) | ops_result_i.sticky;
    round_up     = guard & (round_sticky | body[0]);  // nearest, ties to even
    mag          = {1'b0, body + round_up};
    if (k >= N - 2) begin
      mag = MAXPOS;
    end else if (k < -(N - 2)) begin
      mag = MINPOS;  // a nonzero result never rounds to zero
    end
    posit = ops_result_i.sign ? (~mag + 1'b1) : mag;

    if (p_special_i.is_nar || p_special_i.is_zero) begin
      posit_o = p_special_i.posit;
    end else if (ops_result_i.frac == '0) begin
      posit_o = '0;  // exact cancellation
    end else begin
      posit_o = posit;
    end
  end

endmodule

// ==== source/ppu_core_ops.sv ====
`include "ppu_defines.svh"

module ppu_core_ops #(
  parameter int N  = `PPU_N,
  parameter int ES = `PPU_ES
) (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                stall_i,
  input  ppu_pkg::posit_t     p1_i,
  input  ppu_pkg::posit_t     p2_i,
  input  ppu_pkg::operation_e op_i,
  output ppu_pkg::operation_e op_o,
  output ppu_pkg::posit_t     pout_o
);

  import ppu_pkg::*;

  fir_t           fir1;
  fir_t           fir2;
  posit_special_t p_special;
  posit_special_t special_q;
  ops_result_t    ops_result;

  extraction #(
    .N           (N),
    .ES          (ES)
  ) extraction_inst (
    .p1_i        (p1_i),
    .p2_i        (p2_i),
    .op_i        (op_i),
    .fir1_o      (fir1),
    .fir2_o      (fir2),
    .p_special_o (p_special)
  );

  // the only register stage of the core
  fir_ops #(
    .N            (N)
  ) fir_ops_inst (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .stall_i      (stall_i),
    .op_i         (op_i),
    .fir1_i       (fir1),
    .fir2_i       (fir2),
    .p_special_i  (p_special),
    .ops_result_o (ops_result),
    .special_o    (special_q),
    .op_o         (op_o)
  );

  normalization #(
    .N            (N),
    .ES           (ES)
  ) normalization_inst (
    .ops_result_i (ops_result),
    .p_special_i  (special_q),
    .posit_o      (pout_o)
  );

endmodule

// ==== testbench/ppu_core_ops_properties.sv ====
module ppu_core_ops_properties (
  input logic                clk_i,
  input logic                rst_i,
  input logic                stall_i,
  input ppu_pkg::operation_e op_i,
  input ppu_pkg::operation_e op_o,
  input ppu_pkg::posit_t     pout_o
);

  import ppu_pkg::*;

  int failures = 0;  // assertion failures seen so far

  // the cleared register shows a nop right after reset
  nop_after_reset: assert property (@(posedge clk_i) $past(rst_i) |-> op_o == OP_NOP)
    else begin
      $error("op_o is not OP_NOP after reset");
      failures++;
    end

  hold_on_stall: assert property (@(posedge clk_i) disable iff (rst_i)
    !$past(rst_i) && $past(stall_i) |-> $stable(pout_o) && $stable(op_o))
    else begin
      $error("outputs changed across a stalled edge");
      failures++;
    end

  op_follows_input: assert property (@(posedge clk_i) disable iff (rst_i)
    !$past(rst_i) && !$past(stall_i) |-> op_o == $past(op_i))
    else begin
      $error("op_o does not match op_i of the last accepted edge");
      failures++;
    end

endmodule

bind ppu_core_ops ppu_core_ops_properties properties_inst (
  .clk_i   (clk_i),
  .rst_i   (rst_i),
  .stall_i (stall_i),
  .op_i    (op_i),
  .op_o    (op_o),
  .pout_o  (pout_o)
);

// ==== testbench/tb_ppu_core_ops.sv ====
`include "ppu_defines.svh"

module tb_ppu_core_ops;

  import ppu_pkg::*;

  localparam int     N           = `PPU_N;
  localparam int     ES          = `PPU_ES;
  localparam posit_t NAR         = {1'b1, {(N - 1){1'b0}}};
  localparam int     N_DIRECTED  = 16;
  localparam int     N_RANDOM    = 200;
  localparam int     N_STALL     = 200;  // cycles of which roughly a quarter are stalled
  localparam int     CYCLE_LIMIT = 2 * (N_DIRECTED + N_RANDOM + N_STALL) + 100;

  logic       clk = 1'b0;
  logic       rst;
  logic       stall;
  posit_t     p1;
  posit_t     p2;
  operation_e op_in;
  operation_e op_out;
  posit_t     pout;
  logic       pending = 1'b0;  // the last rising edge accepted an operation
  int         cycles = 0;
  int         checks = 0;
  int         errors = 0;
  int         mark_checks = 0;
  int         mark_errors = 0;
  posit_t     exp_posit_q[$];
  operation_e exp_op_q[$];

  always #4 clk = ~clk;

  ppu_core_ops DUT (
    .clk_i   (clk),
    .rst_i   (rst),
    .stall_i (stall),
    .p1_i    (p1),
    .p2_i    (p2),
    .op_i    (op_in),
    .op_o    (op_out),
    .pout_o  (pout)
  );

  function automatic real pow2(input int e);
    real r;
    r = 1.0;
    for (int i = 0; i < e; i++) r = r * 2.0;
    for (int i = 0; i > e; i--) r = r / 2.0;
    return r;
  endfunction

  function automatic real posit_to_real(input posit_t p);
    posit_t mag;
    logic   lead;
    logic   in_run;
    int     run;
    int     k;
    int     e;
    int     idx;
    real    frac;
    real    step;
    if (p == '0) return 0.0;
    mag = p[N-1] ? posit_t'(-p) : p;
    lead = mag[N-2];
    run = 0;
    in_run = 1'b1;
    for (int i = N - 2; i >= 0; i--) begin
      if (in_run && mag[i] == lead) run++;
      else in_run = 1'b0;
    end
    k = lead ? run - 1 : -run;
    idx = N - 3 - run;  // first bit behind the regime terminator
    e = 0;
    for (int i = 0; i < ES; i++) begin
      e = e * 2 + ((idx >= 0) ? int'(mag[idx]) : 0);
      idx--;
    end
    frac = 1.0;
    step = 0.5;
    for (int i = idx; i >= 0; i--) begin
      if (mag[i]) frac = frac + step;
      step = step / 2.0;
    end
    return (p[N-1] ? -frac : frac) * pow2(k * (1 << ES) + e);
  endfunction

  // exact result in real arithmetic rounded to the nearest nonzero posit with ties to even
  function automatic posit_t ref_result(input posit_t a, input posit_t b, input operation_e op);
    real    x;
    real    err;
    real    best_err;
    posit_t best;
    if (op == OP_NOP) return '0;
    if (a == NAR || b == NAR) return NAR;
    case (op)
      OP_ADD:  x = posit_to_real(a) + posit_to_real(b);
      OP_SUB:  x = posit_to_real(a) - posit_to_real(b);
      default: x = posit_to_real(a) * posit_to_real(b);
    endcase
    if (x == 0.0) return '0;
    best = '0;
    best_err = -1.0;
    for (int i = 1; i < (1 << N); i++) begin
      if (posit_t'(i) != NAR) begin
        err = posit_to_real(posit_t'(i)) - x;
        if (err < 0.0) err = -err;
        if (best_err < 0.0 || err < best_err || (err == best_err && i % 2 == 0)) begin
          best = posit_t'(i);
          best_err = err;
        end
      end
    end
    return best;
  endfunction

  task automatic check(input logic [31:0] got, input logic [31:0] expected, input string what);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("Fail at time %0t: %s is %h, expected %h", $time, what, got, expected);
    end
  endtask

  task automatic drive(input posit_t a, input posit_t b, input operation_e op, input logic stall_v);
    @(negedge clk);
    p1 = a;
    p2 = b;
    op_in = op;
    stall = stall_v;
    if (!stall_v) begin  // a stalled edge drops these operands
      exp_posit_q.push_back(ref_result(a, b, op));
      exp_op_q.push_back(op);
    end
  endtask

  task automatic end_test(input string name);
    @(negedge clk);
    stall = 1'b1;
    while (exp_op_q.size() != 0) begin
      @(negedge clk);
    end
    $display("test %s: %0d checks, %0d errors", name, checks - mark_checks, errors - mark_errors);
    mark_checks = checks;
    mark_errors = errors;
  endtask

  always @(posedge clk) pending <= !rst && !stall;

  // results are compared on the falling edge half a cycle after the register updates
  always @(negedge clk) begin
    if (pending) begin
      if (exp_op_q.size() == 0) begin
        errors++;
        $display("a result came out at time %0t with no operation waiting for it", $time);
      end else begin
        check(pout, exp_posit_q.pop_front(), "pout_o");
        check(op_out, exp_op_q.pop_front(), "op_o");
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Result: FAILED");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'he577_c4f9));
    rst = 1'b1;
    stall = 1'b1;
    p1 = '0;
    p2 = '0;
    op_in = OP_NOP;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    repeat (3) begin
      @(negedge clk);
      check(op_out, OP_NOP, "op_o after reset");
      check(pout, '0, "pout_o after reset");
    end
    end_test("reset");
    drive('h40, 'h40, OP_ADD, 1'b0);  // equal exponents
    drive('h40, 'h20, OP_ADD, 1'b0);
    drive('h60, 'h50, OP_ADD, 1'b0);
    drive('h50, 'h50, OP_SUB, 1'b0);  // exact cancellation
    drive('h20, 'h60, OP_SUB, 1'b0);  // negative result
    drive('h40, 'hC0, OP_ADD, 1'b0);
    end_test("add_sub");
    drive('h40, 'h68, OP_MUL, 1'b0);  // one times x
    drive('h68, 'h00, OP_MUL, 1'b0);
    drive('h7F, 'h7F, OP_MUL, 1'b0);  // saturates at maxpos
    drive('h01, 'h01, OP_MUL, 1'b0);  // stays at minpos
    drive('h70, 'h70, OP_MUL, 1'b0);
    drive('hC0, 'h50, OP_MUL, 1'b0);
    end_test("mul");
    drive(NAR, 'h40, OP_ADD, 1'b0);
    drive('h40, NAR, OP_SUB, 1'b0);
    drive(NAR, 'h00, OP_MUL, 1'b0);
    drive('h00, NAR, OP_MUL, 1'b0);
    end_test("nar");
    repeat (N_RANDOM) begin
      drive(posit_t'($urandom), posit_t'($urandom), operation_e'($urandom % 4), 1'b0);
    end
    end_test("random");
    repeat (N_STALL) begin
      drive(posit_t'($urandom), posit_t'($urandom), operation_e'($urandom % 4),
            ($urandom % 4) == 0);
    end
    end_test("random_stall");
    errors = errors + DUT.properties_inst.failures;
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== ppu_core_ops.f ====
+incdir+source
source/ppu_pkg.sv
source/extraction.sv
source/fir_ops.sv
source/normalization.sv
source/ppu_core_ops.sv
testbench/ppu_core_ops_properties.sv
testbench/tb_ppu_core_ops.sv

// ==== Bender.yml ====
package:
  name: ppu_core_ops

export_include_dirs:
  - source

sources:
  - files:
      - source/ppu_pkg.sv
      - source/extraction.sv
      - source/fir_ops.sv
      - source/normalization.sv
      - source/ppu_core_ops.sv
  - target: test
    files:
      - testbench/ppu_core_ops_properties.sv
      - testbench/tb_ppu_core_ops.sv
